/* design/componentSettings.svh */
`ifndef COMPONENT_SETTINGS_SVH
`define COMPONENT_SETTINGS_SVH

// Hypercube dimension, one coordinate bit per dimension
`define CC_DIM 7

// One bit per vertex of the hypercube
`define CC_GRAPH_WIDTH (1 << `CC_DIM)

// Parallel counter cores, kept a power of two for the round-robin pointer
`define CC_NUM_CORES 4

`define CC_TAG_WIDTH 8

`define CC_COUNT_WIDTH 8

`endif

/* design/componentPkg.sv */
`default_nettype none

`include "componentSettings.svh"

package componentPkg;

    // Vertex set, bit index is the coordinate word of the vertex
    typedef logic [`CC_GRAPH_WIDTH-1:0] graphT;
    typedef logic [`CC_TAG_WIDTH-1:0] tagT;
    typedef logic [`CC_COUNT_WIDTH-1:0] countT;
    typedef logic [$clog2(`CC_NUM_CORES)-1:0] coreIdT;

    typedef struct packed {
        graphT graph;
        graphT top;
        tagT tag;
    } jobT;

    typedef struct packed {
        countT count;
        tagT tag;
    } resultT;

    typedef enum logic [1:0] {
        IDLE,
        SEED,
        GROW,
        FINISHED
    } coreStateT;

endpackage

`default_nettype wire

/* design/hypercubeGrowth.sv */
`timescale 1ns/1ps
`default_nettype none

`include "componentSettings.svh"

module hypercubeGrowth (
    input wire componentPkg::graphT leftover,
    input wire componentPkg::graphT top,
    input wire componentPkg::graphT extending,
    output componentPkg::graphT grown,
    output logic converged
);

    localparam int dim = `CC_DIM;
    localparam int graphWidth = `CC_GRAPH_WIDTH;

    // Vertices whose coordinate bit d is clear
    function automatic componentPkg::graphT lowHalfMask(input int d);
        componentPkg::graphT mask;
        for (int v = 0; v < graphWidth; v++) begin
            mask[v] = ((v >> d) & 1) == 0;
        end
        return mask;
    endfunction

    // Stage d holds the closure over the first d dimensions
    componentPkg::graphT upStage [dim+1];
    componentPkg::graphT downStage [dim+1];
    componentPkg::graphT upperSet;
    componentPkg::graphT reachable;

    assign upStage[0] = extending;

    for (genvar d = 0; d < dim; d++) begin : gUp
        localparam componentPkg::graphT lowHalf = lowHalfMask(d);

        // Vertex v pushes itself into v with bit d set
        assign upStage[d+1] = upStage[d] | ((upStage[d] & lowHalf) << (1 << d));
    end

    // Only supersets that lie inside the top set may be passed through
    assign upperSet = upStage[dim] & top;

    assign downStage[0] = upperSet;

    for (genvar d = 0; d < dim; d++) begin : gDown
        localparam componentPkg::graphT lowHalf = lowHalfMask(d);

        // Vertex v with bit d set pushes itself into v with bit d cleared
        assign downStage[d+1] = downStage[d] | ((downStage[d] >> (1 << d)) & lowHalf);
    end

    assign reachable = downStage[dim] & leftover;

    // E itself is always kept, so the step is monotone for any top set
    assign grown = reachable | extending;

    assign converged = (grown == extending);

endmodule

`default_nettype wire

/* design/seedSelector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "componentSettings.svh"

module seedSelector (
    input wire componentPkg::graphT leftover,
    output componentPkg::graphT seed,
    output logic empty
);

    localparam int graphWidth = `CC_GRAPH_WIDTH;
    localparam int numGroups4 = graphWidth / 4;
    localparam int numGroups16 = graphWidth / 16;
    localparam int numGroups64 = graphWidth / 64;

    // One-hot marker of the lowest set flag among four
    function automatic logic [3:0] firstOfFour(input logic [3:0] flags);
        logic [3:0] first;
        first[0] = flags[0];
        first[1] = !flags[0] & flags[1];
        first[2] = !(|flags[1:0]) & flags[2];
        first[3] = !(|flags[2:0]) & flags[3];
        return first;
    endfunction

    // Occupancy of each group at each level
    logic [numGroups4-1:0] hasBit4;
    logic [numGroups16-1:0] hasBit16;
    logic [numGroups64-1:0] hasBit64;

    // First bit inside its 4-bit group, first group inside 16 and inside 64
    componentPkg::graphT firstBit1;
    logic [numGroups4-1:0] firstBit4;
    logic [numGroups16-1:0] firstBit16;
    logic [numGroups64-1:0] firstBit64;

    for (genvar i = 0; i < numGroups4; i++) begin : gLevel4
        assign hasBit4[i] = |leftover[4*i +: 4];
        assign firstBit1[4*i +: 4] = firstOfFour(leftover[4*i +: 4]);
    end

    for (genvar i = 0; i < numGroups16; i++) begin : gLevel16
        assign hasBit16[i] = |hasBit4[4*i +: 4];
        assign firstBit4[4*i +: 4] = firstOfFour(hasBit4[4*i +: 4]);
    end

    for (genvar i = 0; i < numGroups64; i++) begin : gLevel64
        assign hasBit64[i] = |hasBit16[4*i +: 4];
        assign firstBit16[4*i +: 4] = firstOfFour(hasBit16[4*i +: 4]);
    end

    // Two 64-vertex halves at the top level
    assign firstBit64[0] = hasBit64[0];
    assign firstBit64[1] = !hasBit64[0] & hasBit64[1];

    // A vertex is the seed only if it wins at every level above it
    for (genvar v = 0; v < graphWidth; v++) begin : gSeed
        assign seed[v] = firstBit1[v] & firstBit4[v/4] & firstBit16[v/16] & firstBit64[v/64];
    end

    assign empty = !(hasBit64[0] | hasBit64[1]);

endmodule

`default_nettype wire

/* design/componentCounterCore.sv */
`timescale 1ns/1ps
`default_nettype none

module componentCounterCore (
    input wire clk,
    input wire rstN,
    input wire start,
    input wire componentPkg::jobT job,
    output logic idle,
    output logic finished,
    input wire taken,
    output componentPkg::resultT result
);

    componentPkg::coreStateT state;

    // Per-job payload
    componentPkg::graphT leftover;
    componentPkg::graphT topSet;
    componentPkg::graphT extending;
    componentPkg::tagT tag;
    componentPkg::countT count;

    componentPkg::graphT seed;
    componentPkg::graphT grown;
    logic leftoverEmpty;
    logic converged;

    hypercubeGrowth growth_i (
        .leftover(leftover),
        .top(topSet),
        .extending(extending),
        .grown(grown),
        .converged(converged)
    );

    seedSelector seedSelector_i (
        .leftover(leftover),
        .seed(seed),
        .empty(leftoverEmpty)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= componentPkg::IDLE;
        end else begin
            case (state)
                componentPkg::IDLE: if (start) state <= componentPkg::SEED;
                componentPkg::SEED: begin
                    if (leftoverEmpty) state <= componentPkg::FINISHED;
                    else state <= componentPkg::GROW;
                end
                // One growth step per cycle until nothing changes
                componentPkg::GROW: if (converged) state <= componentPkg::SEED;
                componentPkg::FINISHED: if (taken) state <= componentPkg::IDLE;
                default: state <= componentPkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            componentPkg::IDLE: begin
                if (start) begin
                    leftover <= job.graph;
                    topSet <= job.top;
                    tag <= job.tag;
                    count <= '0;
                end
            end
            componentPkg::SEED: begin
                if (!leftoverEmpty) begin
                    extending <= seed;
                    count <= count + 1'b1;
                end
            end
            componentPkg::GROW: begin
                // Finished component leaves the graph
                if (converged) leftover <= leftover & ~extending;
                else extending <= grown;
            end
            default: ;
        endcase
    end

    assign idle = (state == componentPkg::IDLE);
    assign finished = (state == componentPkg::FINISHED);

    assign result.count = count;
    assign result.tag = tag;

endmodule

`default_nettype wire

/* design/jobDistributor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "componentSettings.svh"

module jobDistributor (
    input wire clk,
    input wire rstN,
    input wire jobValid,
    input wire componentPkg::jobT jobIn,
    input wire [`CC_NUM_CORES-1:0] coreIdle,
    output logic jobReady,
    output logic [`CC_NUM_CORES-1:0] coreStart,
    output componentPkg::jobT coreJob
);

    localparam int numCores = `CC_NUM_CORES;

    // A core with a start in flight still reads idle for one cycle
    logic [numCores-1:0] availCores;
    logic [numCores-1:0] startNext;
    componentPkg::coreIdT pick;
    logic accept;

    assign availCores = coreIdle & ~coreStart;
    assign jobReady = |availCores;
    assign accept = jobValid & jobReady;

    // Lowest-numbered available core wins
    always_comb begin
        pick = '0;
        for (int i = numCores - 1; i >= 0; i--) begin
            if (availCores[i]) pick = componentPkg::coreIdT'(i);
        end
        startNext = '0;
        startNext[pick] = accept;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            coreStart <= '0;
        end else begin
            coreStart <= startNext;
        end
    end

    // Shared job bus, lines up with the registered start
    always_ff @(posedge clk) begin
        if (accept) coreJob <= jobIn;
    end

endmodule

`default_nettype wire

/* design/resultCollector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "componentSettings.svh"

module resultCollector (
    input wire clk,
    input wire rstN,
    input wire [`CC_NUM_CORES-1:0] coreFinished,
    input wire componentPkg::resultT coreResult [`CC_NUM_CORES],
    output logic [`CC_NUM_CORES-1:0] coreTaken,
    output logic resultValid,
    output componentPkg::resultT resultOut
);

    localparam int numCores = `CC_NUM_CORES;

    componentPkg::coreIdT rrPtr;
    componentPkg::coreIdT grantIdx;
    logic grantValid;
    logic [numCores-1:0] justTaken;
    logic [numCores-1:0] eligible;

    // Core granted last cycle is still leaving FINISHED
    assign eligible = coreFinished & ~justTaken;

    // First eligible core at or after the pointer, wrapping around
    always_comb begin
        componentPkg::coreIdT candidate;
        grantIdx = rrPtr;
        grantValid = 1'b0;
        for (int k = 0; k < numCores; k++) begin
            candidate = componentPkg::coreIdT'(rrPtr + k);
            if (!grantValid && eligible[candidate]) begin
                grantIdx = candidate;
                grantValid = 1'b1;
            end
        end
        coreTaken = '0;
        coreTaken[grantIdx] = grantValid;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rrPtr <= '0;
            resultValid <= 1'b0;
            justTaken <= '0;
        end else begin
            resultValid <= grantValid;
            justTaken <= coreTaken;
            if (grantValid) rrPtr <= grantIdx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (grantValid) resultOut <= coreResult[grantIdx];
    end

endmodule

`default_nettype wire

/* design/componentCounterTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "componentSettings.svh"

module componentCounterTop (
    input wire clk,
    input wire rstN,
    input wire jobValid,
    input wire componentPkg::jobT jobIn,
    output logic jobReady,
    output logic resultValid,
    output componentPkg::resultT resultOut
);

    localparam int numCores = `CC_NUM_CORES;

    logic [numCores-1:0] coreIdle;
    logic [numCores-1:0] coreStart;
    logic [numCores-1:0] coreFinished;
    logic [numCores-1:0] coreTaken;
    componentPkg::jobT coreJob;
    componentPkg::resultT coreResult [numCores];

    jobDistributor jobDistributor_i (
        .clk(clk),
        .rstN(rstN),
        .jobValid(jobValid),
        .jobIn(jobIn),
        .coreIdle(coreIdle),
        .jobReady(jobReady),
        .coreStart(coreStart),
        .coreJob(coreJob)
    );

    // All cores share the job bus, start picks the one that loads it
    for (genvar i = 0; i < numCores; i++) begin : gCore
        componentCounterCore componentCounterCore_i (
            .clk(clk),
            .rstN(rstN),
            .start(coreStart[i]),
            .job(coreJob),
            .idle(coreIdle[i]),
            .finished(coreFinished[i]),
            .taken(coreTaken[i]),
            .result(coreResult[i])
        );
    end

    resultCollector resultCollector_i (
        .clk(clk),
        .rstN(rstN),
        .coreFinished(coreFinished),
        .coreResult(coreResult),
        .coreTaken(coreTaken),
        .resultValid(resultValid),
        .resultOut(resultOut)
    );

endmodule

`default_nettype wire

/* testbench/componentModel.svh */
`ifndef COMPONENT_MODEL_SVH
`define COMPONENT_MODEL_SVH

// Galois LFSR state, one step for every random bit taken
logic [31:0] lfsrState = 32'hf3cbd681;

function automatic logic [31:0] randomBits(input int numBits);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < numBits; i++) begin
        value = {value[30:0], lfsrState[0]};
        lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
    end
    return value;
endfunction

// Every superset of a vertex in the set
function automatic componentPkg::graphT upClosure(input componentPkg::graphT s);
    componentPkg::graphT closure;
    closure = s;
    for (int d = 0; d < `CC_DIM; d++) begin
        for (int v = 0; v < `CC_GRAPH_WIDTH; v++) begin
            if (!v[d] && closure[v]) closure[v | (1 << d)] = 1'b1;
        end
    end
    return closure;
endfunction

// Every subset of a vertex in the set
function automatic componentPkg::graphT downClosure(input componentPkg::graphT s);
    componentPkg::graphT closure;
    closure = s;
    for (int d = 0; d < `CC_DIM; d++) begin
        for (int v = 0; v < `CC_GRAPH_WIDTH; v++) begin
            if (!v[d] && closure[v | (1 << d)]) closure[v] = 1'b1;
        end
    end
    return closure;
endfunction

function automatic int countComponents(input componentPkg::graphT graph,
                                       input componentPkg::graphT top);
    componentPkg::graphT leftover;
    componentPkg::graphT ext;
    componentPkg::graphT prev;
    int count;
    int seedVertex;
    leftover = graph;
    count = 0;
    while (leftover != '0) begin
        seedVertex = 0;
        while (!leftover[seedVertex]) seedVertex++;
        ext = '0;
        ext[seedVertex] = 1'b1;
        // Grow until the extending set stops changing
        do begin
            prev = ext;
            ext = ext | (leftover & downClosure(upClosure(ext) & top));
        end while (ext != prev);
        leftover = leftover & ~ext;
        count++;
    end
    return count;
endfunction

`endif

/* testbench/componentCounterTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "componentSettings.svh"

module componentCounterTb;

    localparam int numRandomJobs = 300;
    localparam int numBurstJobs = 12;
    localparam int numTags = 1 << `CC_TAG_WIDTH;
    localparam int timeoutCycles = numRandomJobs * (`CC_GRAPH_WIDTH * 9 + 8);

    logic clk = 1'b0;
    logic rstN = 1'b0;
    logic jobValid = 1'b0;
    componentPkg::jobT jobIn = '0;
    logic jobReady;
    logic resultValid;
    componentPkg::resultT resultOut;

    // Scoreboard indexed by tag
    int expectedCount [numTags];
    string jobName [numTags];
    logic [numTags-1:0] pending = '0;
    int outstanding = 0;
    int cycles = 0;
    componentPkg::tagT nextTag = '0;
    logic sawBusy = 1'b0;

    `include "componentModel.svh"

    componentCounterTop componentCounterTop_i (
        .clk(clk),
        .rstN(rstN),
        .jobValid(jobValid),
        .jobIn(jobIn),
        .jobReady(jobReady),
        .resultValid(resultValid),
        .resultOut(resultOut)
    );

    always #50 clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "testbench stopped");
    endtask

    task automatic checkValue(input string testName, input int expected, input int actual);
        if (expected != actual) begin
            failRun($sformatf("mismatch %s expected %0d actual %0d", testName, expected, actual));
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeoutCycles) failRun($sformatf("run timed out after %0d cycles", cycles));
    end

    // Job on the bus is taken at the coming edge
    task automatic recordJob(input string name, input int expected);
        if (pending[jobIn.tag]) failRun($sformatf("tag %0d reused while in flight", jobIn.tag));
        expectedCount[jobIn.tag] = expected;
        jobName[jobIn.tag] = name;
        pending[jobIn.tag] = 1'b1;
        outstanding++;
        nextTag++;
    endtask

    task automatic driveJob(input componentPkg::graphT graph, input componentPkg::graphT top);
        @(posedge clk);
        jobValid <= 1'b1;
        jobIn.graph <= graph;
        jobIn.top <= top;
        jobIn.tag <= nextTag;
    endtask

    // Strobe stays up until jobReady lets the job in
    task automatic sendJob(input string name, input componentPkg::graphT graph,
                           input componentPkg::graphT top, input int expected);
        driveJob(graph, top);
        @(negedge clk);
        while (!jobReady) @(negedge clk);
        recordJob(name, expected);
        @(posedge clk);
        jobValid <= 1'b0;
    endtask

    task automatic drain();
        while (outstanding != 0) @(negedge clk);
    endtask

    function automatic componentPkg::graphT randomSet(input logic [3:0] density);
        componentPkg::graphT s;
        for (int v = 0; v < `CC_GRAPH_WIDTH; v++) s[v] = (randomBits(4) <= density);
        return s;
    endfunction

    function automatic componentPkg::graphT weightLayer(input int weight);
        componentPkg::graphT s;
        for (int v = 0; v < `CC_GRAPH_WIDTH; v++) s[v] = ($countones(v) == weight);
        return s;
    endfunction

    always @(negedge clk) begin
        if (rstN && resultValid !== 1'b0) begin
            if (resultValid !== 1'b1) failRun("resultValid went unknown");
            if (pending[resultOut.tag] !== 1'b1) begin
                failRun($sformatf("result came back with unknown or repeated tag %0d",
                                  resultOut.tag));
            end
            checkValue(jobName[resultOut.tag], expectedCount[resultOut.tag], resultOut.count);
            pending[resultOut.tag] = 1'b0;
            outstanding--;
        end
    end

    initial begin
        componentPkg::graphT graph;
        componentPkg::graphT top;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("readyAfterReset", 1, jobReady);
        checkValue("noResultAfterReset", 0, resultValid);
        sendJob("emptyGraph", '0, '0, 0);
        sendJob("fullGraph", '1, '1, 1);
        sendJob("weightThreeLayer", weightLayer(3), weightLayer(3), 35);
        drain();
        for (int i = 0; i < numRandomJobs; i++) begin
            graph = randomSet(randomBits(4));
            top = randomSet(randomBits(4));
            repeat (randomBits(2)) @(posedge clk);
            sendJob("randomJob", graph, top, countComponents(graph, top));
        end
        drain();
        // Strobe every cycle, a job counts only when jobReady was high
        for (int i = 0; i < numBurstJobs; i++) begin
            graph = randomSet(4'd12);
            top = randomSet(randomBits(4));
            driveJob(graph, top);
            @(negedge clk);
            if (jobReady) recordJob("burstJob", countComponents(graph, top));
            else sawBusy = 1'b1;
        end
        @(posedge clk);
        jobValid <= 1'b0;
        checkValue("burstReadyDrops", 1, sawBusy);
        drain();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
+incdir+testbench
design/componentPkg.sv
design/hypercubeGrowth.sv
design/seedSelector.sv
design/componentCounterCore.sv
design/jobDistributor.sv
design/resultCollector.sv
design/componentCounterTop.sv
testbench/componentCounterTb.sv
